/* source/serial_link_pkg.sv */
package serial_link_pkg;

    // Width of one data word carried by a frame
    parameter int word_bits_default = 4;

    // The two wires of the link, both high when the link is idle
    typedef struct packed {
        logic scl;
        logic sda;
    } bus_lines_t;

    // Sender states, one per cycle of a frame plus the handshake steps
    typedef enum logic [2:0] {
        idle      = 3'd0,  // Lines high while waiting for req
        capture   = 3'd1,  // Word held while taken is high
        start     = 3'd2,  // sda low with scl high
        bit_low   = 3'd3,  // scl low and sda set to the next bit
        bit_high  = 3'd4,  // scl high with sda held
        stop_low  = 3'd5,
        stop_high = 3'd6,
        stop_rise = 3'd7   // sda rises with scl high
    } tx_state_t;

    // Receiver states
    typedef enum logic [1:0] {
        hunt      = 2'd0,  // Looking for a start condition
        data      = 2'd1,  // Shifting in bits on scl rising
        wait_stop = 2'd2   // All bits in and waiting for sda to rise with scl high
    } rx_state_t;

endpackage

/* source/frame_sender.sv */
`timescale 1ns/100ps

module frame_sender
#(
    parameter int word_bits = serial_link_pkg::word_bits_default
)
(
    input  logic                        ack,
    input  logic                        rst,
    input  logic [word_bits-1:0]        word,
    input  logic                        req,
    output logic                        taken,
    output serial_link_pkg::bus_lines_t lines
);

    localparam int cnt_bits = $clog2(word_bits + 1);

    serial_link_pkg::tx_state_t state;
    serial_link_pkg::tx_state_t state_next;

    logic [word_bits-1:0] shift_reg;
    logic [cnt_bits-1:0]  bit_cnt;
    logic                 last_bit;
    logic                 accept;

    // A new word is only taken once the previous handshake has fully closed
    assign accept   = (state == serial_link_pkg::idle) && req && !taken;
    assign last_bit = (bit_cnt == cnt_bits'(word_bits - 1));

    always_comb
    begin
        state_next = state;
        case (state)
            serial_link_pkg::idle:
            begin
                if (accept)
                begin
                    state_next = serial_link_pkg::capture;
                end
            end
            serial_link_pkg::capture:   state_next = serial_link_pkg::start;
            serial_link_pkg::start:     state_next = serial_link_pkg::bit_low;
            serial_link_pkg::bit_low:   state_next = serial_link_pkg::bit_high;
            serial_link_pkg::bit_high:
            begin
                if (last_bit)
                begin
                    state_next = serial_link_pkg::stop_low;
                end
                else
                begin
                    state_next = serial_link_pkg::bit_low;
                end
            end
            serial_link_pkg::stop_low:  state_next = serial_link_pkg::stop_high;
            serial_link_pkg::stop_high: state_next = serial_link_pkg::stop_rise;
            serial_link_pkg::stop_rise: state_next = serial_link_pkg::idle;
            default:                    state_next = serial_link_pkg::idle;
        endcase
    end

    // Line levels follow directly from the state and the current MSB
    always_comb
    begin
        lines.scl = 1'b1;
        lines.sda = 1'b1;
        case (state)
            serial_link_pkg::start:
            begin
                lines.sda = 1'b0;
            end
            serial_link_pkg::bit_low:
            begin
                lines.scl = 1'b0;
                lines.sda = shift_reg[word_bits-1];
            end
            serial_link_pkg::bit_high:
            begin
                lines.sda = shift_reg[word_bits-1];  // Held while scl is high
            end
            serial_link_pkg::stop_low:
            begin
                lines.scl = 1'b0;
                lines.sda = 1'b0;
            end
            serial_link_pkg::stop_high:
            begin
                lines.sda = 1'b0;
            end
            default:
            begin
                lines.scl = 1'b1;  // Idle, capture and the stop rise
            end
        endcase
    end

    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
        begin
            state   <= serial_link_pkg::idle;
            taken   <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            state <= state_next;

            if (accept)
            begin
                taken <= 1'b1;
            end
            else if (taken && !req)
            begin
                taken <= 1'b0;  // May drop while the frame is still running
            end

            if (state == serial_link_pkg::capture)
            begin
                bit_cnt <= '0;
            end
            else if (state == serial_link_pkg::bit_high)
            begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Word is loaded on acceptance and shifted out MSB first
    always_ff @(posedge ack)
    begin
        if (accept)
        begin
            shift_reg <= word;
        end
        else if (state == serial_link_pkg::bit_high)
        begin
            shift_reg <= shift_reg << 1;
        end
    end

endmodule

/* source/frame_receiver.sv */
`timescale 1ns/100ps

module frame_receiver
#(
    parameter int word_bits = serial_link_pkg::word_bits_default
)
(
    input  logic                        ack,
    input  logic                        rst,
    input  serial_link_pkg::bus_lines_t lines,
    output logic [word_bits-1:0]        rx_word,
    output logic                        rx_valid
);

    localparam int cnt_bits = $clog2(word_bits + 1);

    serial_link_pkg::rx_state_t  state;
    serial_link_pkg::bus_lines_t prev_lines;

    logic [cnt_bits-1:0] bit_cnt;
    logic                scl_rise;
    logic                start_seen;
    logic                stop_seen;
    logic                shift_en;

    assign scl_rise   = !prev_lines.scl && lines.scl;
    // Start and stop are the only sda edges allowed while scl stays high
    assign start_seen = prev_lines.scl && lines.scl && prev_lines.sda && !lines.sda;
    assign stop_seen  = prev_lines.scl && lines.scl && !prev_lines.sda && lines.sda;
    assign shift_en   = (state == serial_link_pkg::data) && !start_seen && scl_rise;

    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
        begin
            prev_lines <= '1;  // Idle high, so no false start after reset
            state      <= serial_link_pkg::hunt;
            bit_cnt    <= '0;
            rx_valid   <= 1'b0;
        end
        else
        begin
            prev_lines <= lines;
            rx_valid   <= 1'b0;
            case (state)
                serial_link_pkg::hunt:
                begin
                    if (start_seen)
                    begin
                        state   <= serial_link_pkg::data;
                        bit_cnt <= '0;
                    end
                end
                serial_link_pkg::data:
                begin
                    if (start_seen)
                    begin
                        bit_cnt <= '0;  // Repeated start begins the word again
                    end
                    else if (scl_rise)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == cnt_bits'(word_bits - 1))
                        begin
                            state <= serial_link_pkg::wait_stop;
                        end
                    end
                end
                serial_link_pkg::wait_stop:
                begin
                    if (stop_seen)
                    begin
                        state    <= serial_link_pkg::hunt;
                        rx_valid <= 1'b1;
                    end
                    else if (start_seen)
                    begin
                        state   <= serial_link_pkg::data;
                        bit_cnt <= '0;
                    end
                end
                default:
                begin
                    state <= serial_link_pkg::hunt;
                end
            endcase
        end
    end

    // Bits arrive MSB first, so the first one ends up on top
    always_ff @(posedge ack)
    begin
        if (shift_en)
        begin
            rx_word <= (rx_word << 1) | word_bits'(lines.sda);
        end
    end

endmodule

/* source/line_decoder.sv */
`timescale 1ns/100ps

module line_decoder
#(
    parameter int word_bits = serial_link_pkg::word_bits_default
)
(
    input  logic                      ack,
    input  logic                      rst,
    input  logic [word_bits-1:0]      rx_word,
    input  logic                      rx_valid,
    output logic [2**word_bits-1:0]   out_lines,
    output logic                      out_valid
);

    localparam int line_count = 2 ** word_bits;

    logic [line_count-1:0] one_hot;

    always_comb
    begin
        one_hot          = '0;
        one_hot[rx_word] = 1'b1;
    end

    // The selected line stays high until the next word replaces it
    always_ff @(posedge ack or negedge rst)
    begin
        if (!rst)
        begin
            out_lines <= '0;
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= rx_valid;
            if (rx_valid)
            begin
                out_lines <= one_hot;
            end
        end
    end

endmodule

/* source/serial_link_top.sv */
`timescale 1ns/100ps

module serial_link_top
#(
    parameter int word_bits = serial_link_pkg::word_bits_default
)
(
    input  logic                        ack,
    input  logic                        rst,
    input  logic [word_bits-1:0]        word,
    input  logic                        req,
    output logic                        taken,
    output serial_link_pkg::bus_lines_t lines,
    output logic [2**word_bits-1:0]     out_lines,
    output logic                        out_valid
);

    logic [word_bits-1:0] rx_word;
    logic                 rx_valid;

    // Turns each handshaked word into one frame on the link
    frame_sender #(
        .word_bits (word_bits)
    ) u_frame_sender (
        .ack   (ack),
        .rst   (rst),
        .word  (word),
        .req   (req),
        .taken (taken),
        .lines (lines)
    );

    // Listens on the same lines, which are also brought out for observation
    frame_receiver #(
        .word_bits (word_bits)
    ) u_frame_receiver (
        .ack      (ack),
        .rst      (rst),
        .lines    (lines),
        .rx_word  (rx_word),
        .rx_valid (rx_valid)
    );

    line_decoder #(
        .word_bits (word_bits)
    ) u_line_decoder (
        .ack       (ack),
        .rst       (rst),
        .rx_word   (rx_word),
        .rx_valid  (rx_valid),
        .out_lines (out_lines),
        .out_valid (out_valid)
    );

endmodule

/* testbench/serial_link_tb.sv */
`timescale 1ns/100ps

module serial_link_tb;

    localparam int word_bits   = serial_link_pkg::word_bits_default;
    localparam int num_vectors = 16;
    localparam int frame_len   = 2 * word_bits + 4;

    logic                        ack;
    logic                        rst;
    logic [word_bits-1:0]        word;
    logic                        req;
    logic                        taken;
    serial_link_pkg::bus_lines_t lines;
    logic [2**word_bits-1:0]     out_lines;
    logic                        out_valid;

    // Three file entries per vector hold the word, the expected out_lines and the idle gap
    logic [15:0]          vec_mem [0:3*num_vectors-1];
    logic [word_bits-1:0] vec_word [num_vectors];
    logic [15:0]          vec_out [num_vectors];
    int                   vec_gap [num_vectors];
    int                   stop_cycle [num_vectors];

    integer seed        = 32'hfa605d1d;
    int     cycle       = 0;
    int     limit       = 0;
    logic   monitors_on = 1'b0;

    serial_link_pkg::bus_lines_t prev_lines   = 2'b11;
    logic                        prev_taken   = 1'b0;
    logic                        frame_active = 1'b0;
    logic [word_bits:0]          sampled      = '0;
    logic [2**word_bits-1:0]     held_lines   = '0;
    int                          rise_count   = 0;
    int                          frame_idx    = 0;
    int                          accepted     = 0;
    int                          out_count    = 0;

    serial_link_top u_serial_link_top (
        .ack       (ack),
        .rst       (rst),
        .word      (word),
        .req       (req),
        .taken     (taken),
        .lines     (lines),
        .out_lines (out_lines),
        .out_valid (out_valid)
    );

    initial
    begin
        ack = 1'b0;
        forever #5 ack = ~ack;
    end

    always @(posedge ack)
    begin
        cycle <= cycle + 1;
    end

    task check(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected)
        begin
            $display("error at %0d ns: %s, got %0h, expected %0h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task wait_for_taken(input logic level);
        do
        begin
            @(negedge ack);
        end
        while (taken !== level);
    endtask

    task watch_frame();
        if (!frame_active)
        begin
            if (lines != 2'b11)
            begin
                check({prev_lines, lines}, 4'b1110, "lines left idle without a start condition");
                frame_active = 1'b1;
                rise_count   = 0;
                sampled      = '0;
            end
        end
        else if (!prev_lines.scl && lines.scl)
        begin
            rise_count = rise_count + 1;
            sampled    = {sampled[word_bits-1:0], lines.sda};
        end
        else if (prev_lines.scl && lines.scl && (prev_lines.sda != lines.sda))
        begin
            check(lines.sda, 1'b1, "sda fell while scl was high inside a frame");
            // The last scl rise sets up the stop with sda low and the ones before carry data
            check(rise_count, word_bits + 1, "scl rising edges in a frame");
            check(frame_idx < num_vectors, 1, "more frames than vectors");
            check(sampled[word_bits:1], vec_word[frame_idx], "data bits of a frame");
            stop_cycle[frame_idx] = cycle;
            frame_idx             = frame_idx + 1;
            frame_active          = 1'b0;
        end
        prev_lines = lines;
    endtask

    task watch_handshake();
        if (taken && !prev_taken)
        begin
            check(req, 1'b1, "taken rose while req was low");
            check(frame_active, 1'b0, "taken rose while a frame was on the lines");
            check(accepted, frame_idx, "taken rose before the previous frame ended");
            accepted = accepted + 1;
        end
        else if (!taken && prev_taken)
        begin
            check(req, 1'b0, "taken fell while req was still high");
        end
        prev_taken = taken;
    endtask

    task watch_outputs();
        int ones;
        int pos;
        if (out_valid)
        begin
            ones = 0;
            pos  = -1;
            for (int i = 0; i < 2**word_bits; i++)
            begin
                if (out_lines[i])
                begin
                    ones = ones + 1;
                    pos  = i;
                end
            end
            check(out_count < frame_idx, 1, "out_valid without a finished frame");
            check(out_lines, vec_out[out_count], "out_lines at out_valid");
            check(ones, 1, "number of high output lines");
            check(pos, vec_word[out_count], "index of the high output line");
            check(cycle - stop_cycle[out_count], 2, "cycles from stop rise to out_valid");
            held_lines = out_lines;
            out_count  = out_count + 1;
        end
        else
        begin
            check(out_lines, held_lines, "out_lines changed between out_valid pulses");
        end
    endtask

    always @(negedge ack)
    begin
        if (monitors_on)
        begin
            watch_frame();
            watch_handshake();
            watch_outputs();
        end
    end

    initial
    begin
        wait (limit > 0);
        while (cycle < limit)
        begin
            @(posedge ack);
        end
        $display("Timeout, the run did not finish within %0d cycles", limit);
        $display("Test failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        int jitter;
        int max_gap;
        rst     = 1'b0;
        req     = 1'b0;
        word    = '0;
        max_gap = 0;
        $readmemh("testbench/link_vectors.txt", vec_mem);
        for (int k = 0; k < num_vectors; k++)
        begin
            check($isunknown(vec_mem[3*k+2]), 1'b0, "vector file holds fewer entries than needed");
            vec_word[k] = vec_mem[3*k][word_bits-1:0];
            vec_out[k]  = vec_mem[3*k+1];
            vec_gap[k]  = vec_mem[3*k+2];
            if (vec_gap[k] > max_gap)
            begin
                max_gap = vec_gap[k];
            end
        end
        limit = num_vectors * (frame_len + max_gap + 3 + 6) + 20;

        repeat (3) @(posedge ack);
        rst         <= 1'b1;
        monitors_on <= 1'b1;
        @(negedge ack);
        check(taken, 1'b0, "taken after reset");
        check(out_valid, 1'b0, "out_valid after reset");
        check(out_lines, '0, "out_lines after reset");
        check(lines, 2'b11, "lines after reset");

        for (int k = 0; k < num_vectors; k++)
        begin
            jitter = $random(seed) & 3;
            repeat (vec_gap[k] + jitter) @(posedge ack);
            @(posedge ack);
            word <= vec_word[k];
            req  <= 1'b1;
            wait_for_taken(1'b1);
            @(posedge ack);
            req <= 1'b0;  // Word stays put until the next req
            wait_for_taken(1'b0);
        end

        while (out_count < num_vectors)
        begin
            @(negedge ack);
        end
        repeat (5) @(negedge ack);

        if ((out_count == num_vectors) && (frame_idx == num_vectors) && !frame_active)
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("The link produced more frames or output pulses than there are vectors");
            $display("Test failed");
            $fatal(1, "count mismatch at the end of the run");
        end
    end

endmodule

/* testbench/link_vectors.txt */
// Columns: word, expected out_lines (one-hot), idle gap in cycles before req
// All values in hex
3 0008 05
a 0400 00
0 0001 00
f 8000 14
7 0080 02
c 1000 00
1 0002 0a
8 0100 01
e 4000 00
5 0020 1e
b 0800 03
2 0004 00
9 0200 00
6 0040 08
d 2000 00
4 0010 0c

/* build.f */
source/serial_link_pkg.sv
source/frame_sender.sv
source/frame_receiver.sv
source/line_decoder.sv
source/serial_link_top.sv
testbench/serial_link_tb.sv

/* Bender.yml */
package:
  name: serial_link

sources:
  - files:
      - source/serial_link_pkg.sv
      - source/frame_sender.sv
      - source/frame_receiver.sv
      - source/line_decoder.sv
      - source/serial_link_top.sv
  - target: test
    files:
      - testbench/serial_link_tb.sv
